// File: gomba_pkg.sv
`include "gomba_settings.svh"

package gomba_pkg;

    typedef logic [`GOMBA_COORD_W-1:0] coord_t;       // velocity uses two's complement.
    typedef logic [`GOMBA_RGB_W-1:0]   rgb_t;
    typedef logic [`GOMBA_COUNT_W-1:0] frame_count_t;

    // bit 0 is the foot phase, bit 1 the direction, for the four walking poses.
    typedef enum logic [2:0] {
        WALK_LEFT_A  = 3'd0,
        WALK_LEFT_B  = 3'd1,
        WALK_RIGHT_A = 3'd2,
        WALK_RIGHT_B = 3'd3,
        DYING        = 3'd4,
        GONE         = 3'd5
    } walk_state_e;

endpackage

// File: gomba_settings.svh
`ifndef GOMBA_SETTINGS_SVH
`define GOMBA_SETTINGS_SVH

// widths of the data that runs through the sprite.
`define GOMBA_COORD_W       10
`define GOMBA_RGB_W         24
`define GOMBA_COUNT_W       3

// playfield bounds in world columns.
`define GOMBA_X_MIN         0
`define GOMBA_X_MAX         639

// spawn point, the row never changes while walking.
`define GOMBA_X_START       400
`define GOMBA_Y_START       384

`define GOMBA_SIZE          32      // the sprite is square.
`define GOMBA_STEP          2       // pixels per frame.

// frame counts for the re-aim period and the squashed picture.
`define GOMBA_GAIT_FRAMES   4
`define GOMBA_DEATH_FRAMES  4

`endif

// File: gomba_sprite.sv
`timescale 1ns/1ps
`include "gomba_settings.svh"

module gomba_sprite
    import gomba_pkg::*;
(
    input  logic        Clk,
    input  logic        arst_n,
    input  coord_t      pos_x,
    input  coord_t      pos_y,
    input  coord_t      scroll_x,
    input  coord_t      draw_x,
    input  coord_t      draw_y,
    input  walk_state_e state,
    input  rgb_t        frame_a,
    input  rgb_t        frame_b,
    input  rgb_t        frame_squashed,
    output logic        hit,
    output rgb_t        pixel_rgb
);

    localparam logic [`GOMBA_COORD_W:0] SIZE_WIDE = (`GOMBA_COORD_W + 1)'(`GOMBA_SIZE);

    logic [`GOMBA_COORD_W:0] world_x;
    logic [`GOMBA_COORD_W:0] box_right;
    logic [`GOMBA_COORD_W:0] box_bottom;
    logic                    inside_x;
    logic                    inside_y;
    logic                    hit_next;
    rgb_t                    rgb_next;

    // one extra bit keeps the box edges and the scrolled column from wrapping.
    assign world_x    = {1'b0, draw_x} + {1'b0, scroll_x};
    assign box_right  = {1'b0, pos_x} + SIZE_WIDE;
    assign box_bottom = {1'b0, pos_y} + SIZE_WIDE;

    assign inside_x = (world_x >= {1'b0, pos_x}) && (world_x < box_right);
    assign inside_y = (draw_y > pos_y) && ({1'b0, draw_y} < box_bottom); // top row is excluded.
    assign hit_next = inside_x && inside_y && (state != GONE);

    always_comb
    begin
        case (state)
            WALK_LEFT_A, WALK_RIGHT_A: rgb_next = frame_a;
            WALK_LEFT_B, WALK_RIGHT_B: rgb_next = frame_b;
            DYING:                     rgb_next = frame_squashed;
            default:                   rgb_next = '0;
        endcase
    end

    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            hit       <= 1'b0;
            pixel_rgb <= '0;
        end
        else
        begin
            hit       <= hit_next;
            pixel_rgb <= rgb_next;
        end
    end

endmodule

// File: gomba_top.sv
`timescale 1ns/1ps

module gomba_top
    import gomba_pkg::*;
(
    input  logic   Clk,
    input  logic   arst_n,
    input  logic   frame_clk,
    input  logic   alive,
    input  coord_t player_x,
    input  coord_t scroll_x,
    input  coord_t draw_x,
    input  coord_t draw_y,
    input  rgb_t   frame_a,
    input  rgb_t   frame_b,
    input  rgb_t   frame_squashed,
    output coord_t gomba_x,
    output coord_t gomba_y,
    output logic   dead,
    output logic   gone,
    output logic   hit,
    output rgb_t   pixel_rgb
);

    coord_t      pos_x;
    coord_t      pos_y;
    walk_state_e state;

    gomba_walker u_walker
    (
        .Clk       (Clk),
        .arst_n    (arst_n),
        .frame_clk (frame_clk),
        .alive     (alive),
        .player_x  (player_x),
        .pos_x     (pos_x),
        .pos_y     (pos_y),
        .state     (state)
    );

    gomba_sprite u_sprite
    (
        .Clk            (Clk),
        .arst_n         (arst_n),
        .pos_x          (pos_x),
        .pos_y          (pos_y),
        .scroll_x       (scroll_x),
        .draw_x         (draw_x),
        .draw_y         (draw_y),
        .state          (state),
        .frame_a        (frame_a),
        .frame_b        (frame_b),
        .frame_squashed (frame_squashed),
        .hit            (hit),
        .pixel_rgb      (pixel_rgb)
    );

    assign gomba_x = pos_x;
    assign gomba_y = pos_y;

    // dead stays high once gone so the game logic sees a single fall.
    assign dead = (state == DYING) || (state == GONE);
    assign gone = (state == GONE);

endmodule

// File: gomba_walker.sv
`timescale 1ns/1ps
`include "gomba_settings.svh"

module gomba_walker
    import gomba_pkg::*;
(
    input  logic        Clk,
    input  logic        arst_n,
    input  logic        frame_clk,
    input  logic        alive,
    input  coord_t      player_x,
    output coord_t      pos_x,
    output coord_t      pos_y,
    output walk_state_e state
);

    localparam coord_t       X_MIN      = coord_t'(`GOMBA_X_MIN);
    localparam coord_t       X_MAX      = coord_t'(`GOMBA_X_MAX);
    localparam coord_t       X_START    = coord_t'(`GOMBA_X_START);
    localparam coord_t       Y_START    = coord_t'(`GOMBA_Y_START);
    localparam coord_t       SIZE       = coord_t'(`GOMBA_SIZE);
    localparam coord_t       VEL_RIGHT  = coord_t'(`GOMBA_STEP);
    localparam coord_t       VEL_LEFT   = coord_t'(-`GOMBA_STEP);
    localparam frame_count_t GAIT_LAST  = frame_count_t'(`GOMBA_GAIT_FRAMES);
    localparam frame_count_t DEATH_LAST = frame_count_t'(`GOMBA_DEATH_FRAMES);

    logic [1:0]   frame_sync;
    logic         frame_seen;
    logic         tick;
    coord_t       vel;
    coord_t       vel_next;
    frame_count_t count;
    frame_count_t count_next;
    walk_state_e  state_next;
    coord_t       x_stepped;
    coord_t       x_next;
    coord_t       y_next;
    logic         foot_b;
    logic         player_left;

    function automatic walk_state_e walk_pose(input logic go_right, input logic b_foot);
        walk_state_e pose;
        case ({go_right, b_foot})
            2'b00:   pose = WALK_LEFT_A;
            2'b01:   pose = WALK_LEFT_B;
            2'b10:   pose = WALK_RIGHT_A;
            default: pose = WALK_RIGHT_B;
        endcase
        return pose;
    endfunction

    // frame_clk comes from the video timing domain.
    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            frame_sync <= '0;
            frame_seen <= 1'b0;
            tick       <= 1'b0;
        end
        else
        begin
            frame_sync <= {frame_sync[0], frame_clk};
            frame_seen <= frame_sync[1];
            tick       <= frame_sync[1] & ~frame_seen; // one cycle per rising edge.
        end
    end

    assign foot_b      = (state == WALK_LEFT_B) || (state == WALK_RIGHT_B);
    assign player_left = player_x < pos_x;
    assign x_stepped   = pos_x + vel;                  // uses the velocity from before the tick.

    always_comb
    begin
        state_next = state;
        vel_next   = vel;
        count_next = count;
        x_next     = pos_x;
        y_next     = pos_y;
        if (tick)
        begin
            case (state)
                DYING:
                begin
                    count_next = count + 1'b1;
                    if (count == DEATH_LAST)
                    begin
                        state_next = GONE;
                        x_next     = '0;
                        y_next     = '0;
                    end
                end
                GONE:
                begin
                    x_next = '0;
                    y_next = '0;
                end
                default:
                begin
                    x_next = (x_stepped > X_MAX) ? X_MAX : x_stepped;
                    if (!alive)
                    begin
                        state_next = DYING;
                        vel_next   = '0;
                        count_next = '0;
                    end
                    else if (pos_x <= X_MIN)
                    begin
                        state_next = walk_pose(1'b1, !foot_b);
                        vel_next   = VEL_RIGHT;
                    end
                    else if (pos_x + SIZE >= X_MAX)
                    begin
                        state_next = walk_pose(1'b0, !foot_b);
                        vel_next   = VEL_LEFT;
                    end
                    else if (count == GAIT_LAST)
                    begin
                        // Turn toward the player and swap feet.
                        state_next = walk_pose(!player_left, !foot_b);
                        vel_next   = player_left ? VEL_LEFT : VEL_RIGHT;
                        count_next = '0;
                    end
                    else
                    begin
                        count_next = count + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= WALK_LEFT_A;
            vel   <= '0;                                // first move waits for a decision.
            count <= '0;
            pos_x <= X_START;
            pos_y <= Y_START;
        end
        else
        begin
            state <= state_next;
            vel   <= vel_next;
            count <= count_next;
            pos_x <= x_next;
            pos_y <= y_next;
        end
    end

endmodule

// File: list.f
+incdir+.
gomba_pkg.sv
gomba_walker.sv
gomba_sprite.sv
gomba_top.sv
tb_gomba.sv

// File: run.sh
#!/bin/sh
# builds the enemy sprite testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    -f list.f --top-module tb_gomba -o tb_gomba_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build stopped with status $status"
    exit $status
fi

./obj_dir/tb_gomba_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit $status
fi

exit 0

// File: tb_gomba.sv
`timescale 1ns/1ps
`include "gomba_settings.svh"

module tb_gomba
    import gomba_pkg::*;
();

    localparam int COORD_MASK     = (1 << `GOMBA_COORD_W) - 1;
    localparam int X_MIN          = `GOMBA_X_MIN;
    localparam int X_MAX          = `GOMBA_X_MAX;
    localparam int X_START        = `GOMBA_X_START;
    localparam int Y_START        = `GOMBA_Y_START;
    localparam int SIZE           = `GOMBA_SIZE;
    localparam int STEP           = `GOMBA_STEP;
    localparam int GAIT_FRAMES    = `GOMBA_GAIT_FRAMES;
    localparam int DEATH_FRAMES   = `GOMBA_DEATH_FRAMES;
    localparam int RESET_CYCLES   = 16;
    localparam int FRAME_HIGH     = 4;
    localparam int FRAME_LOW      = 12;
    localparam int SETTLE_CYCLES  = 8;
    localparam int WALK_FRAMES    = 24;
    localparam int BOUNCE_TIMEOUT = 400;
    localparam int DEATH_TIMEOUT  = 12;

    typedef struct packed {
        int          x;
        int          y;
        int          vel;
        int          count;
        walk_state_e state;
    } pose_t;

    logic   Clk;
    logic   arst_n;
    logic   frame_clk;
    logic   alive;
    coord_t player_x;
    coord_t scroll_x;
    coord_t draw_x;
    coord_t draw_y;
    rgb_t   frame_a;
    rgb_t   frame_b;
    rgb_t   frame_squashed;
    coord_t gomba_x;
    coord_t gomba_y;
    logic   dead;
    logic   gone;
    logic   hit;
    rgb_t   pixel_rgb;

    integer seed;
    pose_t  model;
    int     i;
    int     dying_frames;

    gomba_top UUT
    (
        .Clk            (Clk),
        .arst_n         (arst_n),
        .frame_clk      (frame_clk),
        .alive          (alive),
        .player_x       (player_x),
        .scroll_x       (scroll_x),
        .draw_x         (draw_x),
        .draw_y         (draw_y),
        .frame_a        (frame_a),
        .frame_b        (frame_b),
        .frame_squashed (frame_squashed),
        .gomba_x        (gomba_x),
        .gomba_y        (gomba_y),
        .dead           (dead),
        .gone           (gone),
        .hit            (hit),
        .pixel_rgb      (pixel_rgb)
    );

    initial
    begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fffffff) % n;
    endfunction

    function automatic walk_state_e facing_pose(input logic right, input logic b_phase);
        if (right)
            return b_phase ? WALK_RIGHT_B : WALK_RIGHT_A;
        return b_phase ? WALK_LEFT_B : WALK_LEFT_A;
    endfunction

    // one frame tick of the walk rule, applied to the model pose.
    function automatic pose_t next_pose(input pose_t p, input int player, input logic alv);
        pose_t n;
        logic  b_phase;
        int    stepped;
        n       = p;
        b_phase = (p.state == WALK_LEFT_B) || (p.state == WALK_RIGHT_B);
        if (p.state == GONE)
        begin
            n.x = 0;
            n.y = 0;
        end
        else if (p.state == DYING)
        begin
            if (p.count == DEATH_FRAMES)
            begin
                n.state = GONE;
                n.x     = 0;
                n.y     = 0;
            end
            n.count = p.count + 1;
        end
        else
        begin
            stepped = (p.x + p.vel) & COORD_MASK;           // velocity wraps like a coordinate.
            n.x     = (stepped > X_MAX) ? X_MAX : stepped;
            if (!alv)
            begin
                n.state = DYING;
                n.vel   = 0;
                n.count = 0;
            end
            else if (p.x <= X_MIN)
            begin
                n.state = facing_pose(1'b1, !b_phase);
                n.vel   = STEP;
            end
            else if (p.x + SIZE >= X_MAX)
            begin
                n.state = facing_pose(1'b0, !b_phase);
                n.vel   = -STEP;
            end
            else if (p.count == GAIT_FRAMES)
            begin
                n.state = facing_pose(!(player < p.x), !b_phase);
                n.vel   = (player < p.x) ? -STEP : STEP;
                n.count = 0;
            end
            else
            begin
                n.count = p.count + 1;
            end
        end
        return n;
    endfunction

    function automatic rgb_t expected_rgb(input walk_state_e st);
        if (st == WALK_LEFT_A || st == WALK_RIGHT_A)
            return frame_a;
        if (st == WALK_LEFT_B || st == WALK_RIGHT_B)
            return frame_b;
        if (st == DYING)
            return frame_squashed;
        return '0;
    endfunction

    function automatic logic expected_hit(input int dx, input int dy, input int sc,
                                          input pose_t p);
        int world;
        world = dx + sc;                                    // screen column moved into the world.
        if (p.state == GONE)
            return 1'b0;
        return (world >= p.x) && (world < p.x + SIZE) && (dy > p.y) && (dy < p.y + SIZE);
    endfunction

    function automatic logic pose_matches();
        return (int'(gomba_x) == model.x)
            && (dead == (model.state == DYING || model.state == GONE))
            && (gone == (model.state == GONE));
    endfunction

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
            stop_with_error($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, expected));
    endtask

    task automatic check_pose();
        if (int'(gomba_x) > X_MAX)
            stop_with_error("gomba_x walked past the right bound of the playfield");
        check_value("gomba_x", 32'(gomba_x), 32'(model.x));
        check_value("gomba_y", 32'(gomba_y), 32'(model.y));
        check_value("dead", 32'(dead), 32'(model.state == DYING || model.state == GONE));
        check_value("gone", 32'(gone), 32'(model.state == GONE));
    endtask

    // pulses the frame strobe once and compares the new pose.
    task automatic run_frame();
        int n;
        @(posedge Clk);
        model = next_pose(model, int'(player_x), alive);
        frame_clk <= 1'b1;
        for (n = 0; n < FRAME_HIGH; n++)
            @(posedge Clk);
        frame_clk <= 1'b0;
        for (n = 0; n < FRAME_LOW; n++)
            @(posedge Clk);
        @(negedge Clk);
        n = 0;
        while (n < SETTLE_CYCLES && !pose_matches())
        begin
            @(negedge Clk);
            n++;
        end
        check_pose();
    endtask

    task automatic probe_pixel(input int dx, input int dy, input int sc);
        @(posedge Clk);
        draw_x   <= coord_t'(dx);
        draw_y   <= coord_t'(dy);
        scroll_x <= coord_t'(sc);
        @(posedge Clk);
        @(negedge Clk);
        check_value("hit", 32'(hit), 32'(expected_hit(dx, dy, sc, model)));
        check_value("pixel_rgb", 32'(pixel_rgb), 32'(expected_rgb(model.state)));
    endtask

    task automatic probe_box(input logic use_scroll);
        int sc;
        int dx;
        int dy;
        sc = use_scroll ? rand_below(model.x + 1) : 0;
        dx = model.x - sc + rand_below(SIZE);
        dy = model.y + 1 + rand_below(SIZE - 1);
        probe_pixel(dx, dy, sc);
        probe_pixel(model.x + SIZE - sc, dy, sc);          // first column right of the box.
    endtask

    task automatic walk_to_bound(input int player, input logic right_side);
        int   frames;
        int   after;
        logic at_bound;
        @(posedge Clk);
        player_x <= coord_t'(player);
        frames = 0;
        after  = -1;
        while (after < 4 && frames < BOUNCE_TIMEOUT)
        begin
            at_bound = right_side ? (model.x + SIZE >= X_MAX) : (model.x <= X_MIN);
            if (after >= 0)
                after++;
            else if (at_bound)
                after = 0;
            run_frame();
            probe_box(1'b0);
            frames++;
        end
        if (after < 4)
        begin
            if (right_side)
                stop_with_error("the enemy never turned back at the right bound");
            else
                stop_with_error("the enemy never turned back at the left bound");
        end
    endtask

    initial
    begin
        seed = 32'h854f480b;
        arst_n         <= 1'b0;
        frame_clk      <= 1'b0;
        alive          <= 1'b1;
        player_x       <= '0;
        scroll_x       <= '0;
        draw_x         <= '0;
        draw_y         <= '0;
        frame_a        <= rgb_t'($random(seed));
        frame_b        <= rgb_t'($random(seed));
        frame_squashed <= rgb_t'($random(seed));
        for (i = 0; i < RESET_CYCLES; i++)
            @(posedge Clk);
        arst_n <= 1'b1;
        @(negedge Clk);

        model.x     = X_START;
        model.y     = Y_START;
        model.vel   = 0;
        model.count = 0;
        model.state = WALK_LEFT_A;
        check_pose();
        check_value("hit", 32'(hit), 32'h0);
        check_value("pixel_rgb", 32'(pixel_rgb), 32'h0);

        for (i = 0; i < WALK_FRAMES; i++)
        begin
            @(posedge Clk);
            player_x <= coord_t'(rand_below(X_MAX + 1));
            run_frame();
            probe_box(1'b1);
        end

        walk_to_bound(X_MAX, 1'b1);
        walk_to_bound(0, 1'b0);

        @(posedge Clk);
        alive <= 1'b0;
        run_frame();                                        // the enemy is hit on this frame.
        probe_box(1'b1);
        dying_frames = 0;
        while (!gone && dying_frames < DEATH_TIMEOUT)
        begin
            run_frame();
            dying_frames++;
            probe_box(1'b1);
        end
        check_value("frames_to_gone", 32'(dying_frames), 32'(DEATH_FRAMES + 1));
        run_frame();
        probe_box(1'b1);

        $display("Verification passed");
        $finish;
    end

endmodule
